//--- rtl/bitScanPkg.sv
package bitScanPkg;

	// ==============================
	// widths
	// ==============================

	// operand width seen by both requesters
	localparam int DataWidth = 64;

	// a count runs from 0 to DataWidth, so it needs one bit more than log2
	localparam int CountWidth = 7;

	// the leading-count core is built from byte-sized lookup tables
	localparam int ByteWidth = 8;

	// integer issue lane and floating-point normalizer
	localparam int PortCount = 2;
	localparam int PortTagWidth = $clog2(PortCount);

	// ==============================
	// operations and payloads
	// ==============================

	typedef enum logic [1:0] {
		opCountZeros = 2'd0,
		opCountOnes  = 2'd1,
		opNormalize  = 2'd2
	} scanOp_e;

	// request from a port, 66 bits
	typedef struct packed {
		scanOp_e              op;
		logic [DataWidth-1:0] operand;
	} scanReq_t;

	// response to a port, 72 bits
	// shifted is only filled in for normalize
	typedef struct packed {
		logic [CountWidth-1:0] count;
		logic                  allSame;
		logic [DataWidth-1:0]  shifted;
	} scanRsp_t;

	// one entry travelling through the engine
	// count and allSame are produced by stage 1
	typedef struct packed {
		logic [PortTagWidth-1:0] port;
		scanOp_e                 op;
		logic [DataWidth-1:0]    operand;
		logic [CountWidth-1:0]   count;
		logic                    allSame;
	} scanItem_t;

endpackage

//--- rtl/leadCount8.sv
`timescale 1ns/1ps

module leadCount8 import bitScanPkg::*; (
	input  logic [ByteWidth-1:0] in,
	output logic [3:0]           count
);

	// leading-zero count of one byte
	// every one of the 256 byte values falls into exactly one row, the
	// first set bit from the top decides the row
	always_comb begin
		casez (in)
			8'b1???????: count = 4'd0;
			8'b01??????: count = 4'd1;
			8'b001?????: count = 4'd2;
			8'b0001????: count = 4'd3;
			8'b00001???: count = 4'd4;
			8'b000001??: count = 4'd5;
			8'b0000001?: count = 4'd6;
			8'b00000001: count = 4'd7;
			// only the all-zero byte is left
			default:     count = 4'd8;
		endcase
	end

endmodule

//--- rtl/leadCountTree.sv
`timescale 1ns/1ps

module leadCountTree import bitScanPkg::*; #(
	parameter int Width = DataWidth
) (
	input  logic [Width-1:0]           in,
	output logic [$clog2(Width+1)-1:0] count
);

	localparam int Bytes = Width / ByteWidth;
	localparam int CountBits = $clog2(Width + 1);

	// per-byte leading-zero counts, index 0 is the least significant byte
	logic [3:0] byteCount [Bytes];

	// ==============================
	// byte lookup tables
	// ==============================

	for (genvar b = 0; b < Bytes; b++) begin : gByte
		leadCount8 byteCounter (
			.in    (in[b*ByteWidth +: ByteWidth]),
			.count (byteCount[b])
		);
	end

	// ==============================
	// priority combine
	// ==============================

	// bit 3 of a byte count is set only for an all-zero byte, so a clear
	// bit 3 marks a byte that ends the scan
	// the loop runs upward, so the highest such byte wins and every byte
	// above it is known to be zero
	always_comb begin
		count = CountBits'(Width);
		for (int b = 0; b < Bytes; b++) begin
			if (!byteCount[b][3]) begin
				count = CountBits'((Bytes - 1 - b) * ByteWidth) + CountBits'(byteCount[b]);
			end
		end
	end

endmodule

//--- rtl/scanArbiter.sv
`timescale 1ns/1ps

module scanArbiter import bitScanPkg::*; (
	input  logic                    clk,
	input  logic                    rst,

	// requester side
	input  logic [PortCount-1:0]    reqValid,
	input  scanReq_t                reqData [PortCount],
	output logic [PortCount-1:0]    reqReady,

	// response side
	output logic [PortCount-1:0]    rspValid,
	output scanRsp_t                rspData [PortCount],
	input  logic [PortCount-1:0]    rspReady,

	// toward the engine
	output logic                    inValid,
	output scanItem_t               inItem,
	input  logic                    inReady,

	// back from the engine
	input  logic                    outValid,
	input  logic [PortTagWidth-1:0] outPort,
	input  scanRsp_t                outRsp,
	output logic                    outReady
);

	// port that wins when both are asking
	logic [PortTagWidth-1:0] rrPtr;
	logic [PortTagWidth-1:0] grantPort;
	logic                    accept;

	// ==============================
	// request arbitration
	// ==============================

	// favored port first, otherwise the other one
	// with two ports the increment wraps to the other port
	always_comb begin
		if (reqValid[rrPtr]) begin
			grantPort = rrPtr;
		end else begin
			grantPort = rrPtr + 1'b1;
		end
	end

	assign inValid = |reqValid;
	assign accept = inValid && inReady;

	always_comb begin
		for (int p = 0; p < PortCount; p++) begin
			reqReady[p] = inValid && inReady && (grantPort == PortTagWidth'(p));
		end
	end

	// the granted request goes in with its port tag, the engine fills in
	// the count fields itself
	always_comb begin
		inItem = '0;
		inItem.port = grantPort;
		inItem.op = reqData[grantPort].op;
		inItem.operand = reqData[grantPort].operand;
	end

	// after every transfer the other port becomes the favored one
	always_ff @(posedge clk) begin
		if (rst) begin
			rrPtr <= '0;
		end else if (accept) begin
			rrPtr <= grantPort + 1'b1;
		end
	end

	// ==============================
	// response routing
	// ==============================

	// data is shared, only the valid of the tagged port rises
	always_comb begin
		for (int p = 0; p < PortCount; p++) begin
			rspValid[p] = outValid && (outPort == PortTagWidth'(p));
			rspData[p] = outRsp;
		end
	end

	assign outReady = rspReady[outPort];

endmodule

//--- rtl/leadCountPipe.sv
`timescale 1ns/1ps

module leadCountPipe import bitScanPkg::*; (
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    inValid,
	input  scanItem_t               inItem,
	output logic                    inReady,

	output logic                    outValid,
	output logic [PortTagWidth-1:0] outPort,
	output scanRsp_t                outRsp,
	input  logic                    outReady
);

	logic [DataWidth-1:0]  conditioned;
	logic [CountWidth-1:0] leadCount;
	logic                  advance;

	// stage 1 holds the counted item, stage 2 the finished response
	logic                    s1Valid;
	scanItem_t               s1Item;
	logic                    s2Valid;
	logic [PortTagWidth-1:0] s2Port;
	scanRsp_t                s2Rsp;

	// the whole pipe freezes while the oldest response waits on its port
	assign advance = !(s2Valid && !outReady);
	assign inReady = advance;

	// ==============================
	// stage 1, condition and count
	// ==============================

	// leading ones are counted as leading zeros of the inverted operand
	assign conditioned = (inItem.op == opCountOnes) ? ~inItem.operand : inItem.operand;

	leadCountTree #(
		.Width (DataWidth)
	) counter (
		.in    (conditioned),
		.count (leadCount)
	);

	always_ff @(posedge clk) begin
		if (advance) begin
			s1Item.port <= inItem.port;
			s1Item.op <= inItem.op;
			s1Item.operand <= conditioned;
			s1Item.count <= leadCount;
			// a count of the full width means no bit ended the run
			s1Item.allSame <= (leadCount == CountWidth'(DataWidth));
		end
	end

	// ==============================
	// stage 2, shift and result
	// ==============================

	always_ff @(posedge clk) begin
		if (advance) begin
			s2Port <= s1Item.port;
			s2Rsp.count <= s1Item.count;
			s2Rsp.allSame <= s1Item.allSame;
			// normalize moves the leading one up to the top bit,
			// the count operations return an empty shifted field
			if (s1Item.op == opNormalize) begin
				s2Rsp.shifted <= s1Item.operand << s1Item.count;
			end else begin
				s2Rsp.shifted <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else if (advance) begin
			s1Valid <= inValid;
			s2Valid <= s1Valid;
		end
	end

	assign outValid = s2Valid;
	assign outPort = s2Port;
	assign outRsp = s2Rsp;

endmodule

//--- rtl/bitScanTop.sv
`timescale 1ns/1ps

module bitScanTop import bitScanPkg::*; (
	input  logic                 clk,
	input  logic                 rst,

	// one request/response pair per port
	input  logic [PortCount-1:0] reqValid,
	input  scanReq_t             reqData [PortCount],
	output logic [PortCount-1:0] reqReady,

	output logic [PortCount-1:0] rspValid,
	output scanRsp_t             rspData [PortCount],
	input  logic [PortCount-1:0] rspReady
);

	// arbiter to engine
	logic      inValid;
	scanItem_t inItem;
	logic      inReady;

	// engine back to arbiter
	logic                    outValid;
	logic [PortTagWidth-1:0] outPort;
	scanRsp_t                outRsp;
	logic                    outReady;

	scanArbiter arbiter (
		.clk      (clk),
		.rst      (rst),
		.reqValid (reqValid),
		.reqData  (reqData),
		.reqReady (reqReady),
		.rspValid (rspValid),
		.rspData  (rspData),
		.rspReady (rspReady),
		.inValid  (inValid),
		.inItem   (inItem),
		.inReady  (inReady),
		.outValid (outValid),
		.outPort  (outPort),
		.outRsp   (outRsp),
		.outReady (outReady)
	);

	leadCountPipe pipe (
		.clk      (clk),
		.rst      (rst),
		.inValid  (inValid),
		.inItem   (inItem),
		.inReady  (inReady),
		.outValid (outValid),
		.outPort  (outPort),
		.outRsp   (outRsp),
		.outReady (outReady)
	);

endmodule

//--- verification/bitScanTb.sv
`timescale 1ns/1ps

module bitScanTb import bitScanPkg::*; ();

	localparam int NumRandom = 40;
	localparam int Latency = 2;

	// one row of the stimulus table with its expected response
	typedef struct packed {
		logic                  port;
		scanOp_e               op;
		logic [DataWidth-1:0]  operand;
		logic [CountWidth-1:0] count;
		logic                  allSame;
		logic [DataWidth-1:0]  shifted;
	} stimEntry_t;

	// an accepted request waiting for its response
	typedef struct packed {
		stimEntry_t entry;
		int         acceptCycle;
	} pending_t;

	logic                 clk;
	logic                 rst;
	logic [PortCount-1:0] reqValid;
	scanReq_t             reqData [PortCount];
	logic [PortCount-1:0] reqReady;
	logic [PortCount-1:0] rspValid;
	scanRsp_t             rspData [PortCount];
	logic [PortCount-1:0] rspReady;

	stimEntry_t stimTable [$];
	stimEntry_t reqList [PortCount][$];
	pending_t   expQ [PortCount][$];

	integer               seed;
	int                   errors = 0;
	int                   checked = 0;
	int                   cycle = 0;
	logic                 checkLatency;
	logic                 stallMode;
	logic                 ptrModel;
	logic [PortCount-1:0] heldLast;
	scanRsp_t             dataLast [PortCount];

	bitScanTop dut_i (
		.clk      (clk),
		.rst      (rst),
		.reqValid (reqValid),
		.reqData  (reqData),
		.reqReady (reqReady),
		.rspValid (rspValid),
		.rspData  (rspData),
		.rspReady (rspReady)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// counted on the falling edge so that it is stable at the rising edge
	always @(negedge clk) cycle <= cycle + 1;

	// ==============================
	// helpers
	// ==============================

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// reference result, found by walking down from the top bit
	function automatic stimEntry_t makeExpected(input logic port, input scanOp_e op,
			input logic [DataWidth-1:0] operand);
		stimEntry_t e;
		logic runBit;
		int n;
		e.port = port;
		e.op = op;
		e.operand = operand;
		runBit = (op == opCountOnes);
		n = 0;
		for (int i = DataWidth - 1; i >= 0; i--) begin
			if (operand[i] != runBit) break;
			n++;
		end
		e.count = CountWidth'(n);
		e.allSame = (n == DataWidth);
		e.shifted = (op == opNormalize) ? operand << n : '0;
		return e;
	endfunction

	task automatic addEntry(input logic port, input scanOp_e op, input logic [DataWidth-1:0] operand,
			input int count, input logic allSame, input logic [DataWidth-1:0] shifted);
		stimEntry_t e;
		e.port = port;
		e.op = op;
		e.operand = operand;
		e.count = CountWidth'(count);
		e.allSame = allSame;
		e.shifted = shifted;
		stimTable.push_back(e);
	endtask

	task automatic buildTable();
		// leading zeros, one set bit in every byte and a few mixed values
		addEntry(0, opCountZeros, 64'h0, 64, 1, 64'h0);
		addEntry(0, opCountZeros, 64'hFFFF_FFFF_FFFF_FFFF, 0, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0000_0000_0080, 56, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0000_0000_4000, 49, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0000_0020_0000, 42, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0000_1000_0000, 35, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0008_0000_0000, 28, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0400_0000_0000, 21, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0002_0000_0000_0000, 14, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0100_0000_0000_0000, 7, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h8000_0000_0000_0000, 0, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0000_0000_00F0_1234, 40, 0, 64'h0);
		addEntry(0, opCountZeros, 64'h0012_3456_789A_BCDE, 11, 0, 64'h0);
		addEntry(0, opNormalize, 64'h0000_0000_0000_0001, 63, 0, 64'h8000_0000_0000_0000);
		// leading ones, with runs that end inside or across bytes
		addEntry(1, opCountOnes, 64'hFFFF_FFFF_FFFF_FFFF, 64, 1, 64'h0);
		addEntry(1, opCountOnes, 64'h0, 0, 0, 64'h0);
		addEntry(1, opCountOnes, 64'hFFFF_F000_0000_0000, 20, 0, 64'h0);
		addEntry(1, opCountOnes, 64'hFF7F_0000_0000_0000, 8, 0, 64'h0);
		addEntry(1, opCountOnes, 64'hFFFF_FFFF_FFFE_1234, 47, 0, 64'h0);
		addEntry(1, opCountOnes, 64'hFFFF_FFFF_FFFF_FFFE, 63, 0, 64'h0);
		// normalize next to a plain count of the same operand
		addEntry(1, opCountZeros, 64'h000A_BCDE_F012_3456, 12, 0, 64'h0);
		addEntry(1, opNormalize, 64'h000A_BCDE_F012_3456, 12, 0, 64'hABCD_EF01_2345_6000);
		addEntry(1, opNormalize, 64'h0, 64, 1, 64'h0);
		addEntry(1, opNormalize, 64'h0000_0000_00F0_1234, 40, 0, 64'hF012_3400_0000_0000);
		addEntry(1, opNormalize, 64'h8000_0000_0000_0001, 0, 0, 64'h8000_0000_0000_0001);
		addEntry(1, opCountZeros, 64'h0000_0000_0000_0003, 62, 0, 64'h0);
		addEntry(1, opNormalize, 64'h0000_0000_0000_0003, 62, 0, 64'hC000_0000_0000_0000);
	endtask

	// ==============================
	// drivers
	// ==============================

	// presents the queued requests of one port back to back
	task automatic driveHost(input int p);
		stimEntry_t e;
		pending_t x;
		while (reqList[p].size() > 0) begin
			e = reqList[p].pop_front();
			@(negedge clk);
			reqValid[p] = 1'b1;
			reqData[p].op = e.op;
			reqData[p].operand = e.operand;
			do begin
				@(posedge clk);
			end while (!reqReady[p]);
			x.entry = e;
			x.acceptCycle = cycle;
			expQ[p].push_back(x);
		end
		@(negedge clk);
		reqValid[p] = 1'b0;
	endtask

	// random stretches of rspReady low on both ports
	task automatic applyBackPressure();
		int left [PortCount];
		left = '{0, 0};
		while (stallMode) begin
			@(negedge clk);
			for (int p = 0; p < PortCount; p++) begin
				if (left[p] == 0) begin
					left[p] = 1 + randBelow(6);
					rspReady[p] = (randBelow(3) != 0);
				end else begin
					left[p]--;
				end
			end
		end
		@(negedge clk);
		rspReady = '1;
	endtask

	task automatic waitDrain();
		while (expQ[0].size() != 0 || expQ[1].size() != 0) begin
			@(negedge clk);
		end
	endtask

	// ==============================
	// checks
	// ==============================

	task automatic compareField(input string name, input logic [DataWidth-1:0] got,
			input logic [DataWidth-1:0] exp);
		if (got != exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkResponse(input int p);
		pending_t x;
		if (expQ[p].size() == 0) begin
			$display("port %0d returned a response with no request pending", p);
			errors++;
		end else begin
			x = expQ[p].pop_front();
			checked++;
			compareField($sformatf("rspData[%0d].count", p), 64'(rspData[p].count),
				64'(x.entry.count));
			compareField($sformatf("rspData[%0d].allSame", p), 64'(rspData[p].allSame),
				64'(x.entry.allSame));
			compareField($sformatf("rspData[%0d].shifted", p), rspData[p].shifted,
				x.entry.shifted);
			if (x.entry.op == opNormalize && x.entry.operand != '0
					&& !rspData[p].shifted[DataWidth-1]) begin
				$display("port %0d normalize result does not have its top bit set", p);
				errors++;
			end
			if (checkLatency && cycle != x.acceptCycle + Latency) begin
				$display("port %0d response came %0d cycles after acceptance instead of %0d",
					p, cycle - x.acceptCycle, Latency);
				errors++;
			end
		end
	endtask

	always @(posedge clk) begin
		int g;
		if (rst) begin
			ptrModel = 1'b0;
			heldLast = '0;
			if (rspValid != '0) begin
				$display("a response was valid while reset was asserted");
				errors++;
			end
		end else begin
			// a granted port must match the round-robin model
			if (reqReady != '0) begin
				g = (reqValid == 2'b11) ? int'(ptrModel) : (reqValid[1] ? 1 : 0);
				if (reqReady != PortCount'(1 << g)) begin
					$display("ERR reqReady got %h expected %h", reqReady, PortCount'(1 << g));
					errors++;
				end
				ptrModel = ~reqReady[1];
			end
			if ((rspValid & ~rspReady) != '0 && reqReady != '0) begin
				$display("a request was accepted while a response was stalled");
				errors++;
			end
			for (int p = 0; p < PortCount; p++) begin
				if (heldLast[p] && !rspValid[p]) begin
					$display("port %0d dropped its response before the transfer", p);
					errors++;
				end
				if (heldLast[p] && rspData[p] != dataLast[p]) begin
					$display("ERR rspData[%0d] got %h expected %h", p, rspData[p], dataLast[p]);
					errors++;
				end
				if (rspValid[p] && rspReady[p]) begin
					checkResponse(p);
				end
				heldLast[p] = rspValid[p] && !rspReady[p];
				dataLast[p] = rspData[p];
			end
		end
	end

	// ==============================
	// main sequence and watchdog
	// ==============================

	initial begin
		stimEntry_t e;
		logic port;
		scanOp_e op;
		logic [DataWidth-1:0] operand;
		seed = 32'h2f3e;
		checkLatency = 1'b1;
		stallMode = 1'b0;
		rst = 1'b1;
		reqValid = '0;
		reqData[0] = '0;
		reqData[1] = '0;
		rspReady = '1;
		buildTable();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		if (rspValid != '0) begin
			$display("a response was valid right after reset");
			errors++;
		end

		// table pass, both ports busy and no back-pressure
		foreach (stimTable[i]) begin
			reqList[stimTable[i].port].push_back(stimTable[i]);
		end
		fork
			driveHost(0);
			driveHost(1);
		join
		waitDrain();

		// random pass under back-pressure
		checkLatency = 1'b0;
		for (int i = 0; i < NumRandom; i++) begin
			port = (randBelow(2) == 1);
			op = scanOp_e'(2'(randBelow(3)));
			operand = {$random(seed), $random(seed)};
			operand = operand >> randBelow(DataWidth);
			if (op == opCountOnes) begin
				operand = ~operand;
			end
			e = makeExpected(port, op, operand);
			reqList[port].push_back(e);
		end
		stallMode = 1'b1;
		fork
			begin
				fork
					driveHost(0);
					driveHost(1);
				join
				stallMode = 1'b0;
			end
			applyBackPressure();
		join
		waitDrain();
		repeat (4) @(negedge clk);

		$display("%0d responses checked, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		int limit;
		@(negedge clk);
		limit = (stimTable.size() + NumRandom) * 20 + 200;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles with the test still running", limit);
		$display("%0d responses checked, %0d errors", checked, errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- project.f
rtl/bitScanPkg.sv
rtl/leadCount8.sv
rtl/leadCountTree.sv
rtl/scanArbiter.sv
rtl/leadCountPipe.sv
rtl/bitScanTop.sv
verification/bitScanTb.sv

//--- run.sh
#!/bin/sh
# builds the bit-scan unit with its testbench in Verilator and runs it

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
	--top-module bitScanTb \
	-f project.f \
	--Mdir obj_dir

./obj_dir/VbitScanTb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
